// ==== src.f ====
hdl/ball_link_pkg.sv
hdl/i2c_pkg.sv
hdl/ball_frame_sender.sv
hdl/i2c_byte_master.sv
hdl/i2c_frame_receiver.sv
hdl/pong_link_top.sv
tests/pong_link_props.sv
tests/pong_link_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vpong_link_tb
SRCS := $(wildcard hdl/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) src.f
	verilator --binary --timing --assert --top-module pong_link_tb \
		-f src.f -o Vpong_link_tb

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@! grep -q "Simulation failed" sim.log
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/pong_link_tb.sv ====
`timescale 1ns/100ps

module pong_link_tb;

    localparam int         CLK_DIV     = 4;
    localparam logic [6:0] TARGET_ADDR = 7'h55;
    localparam int         Y_W         = ball_link_pkg::Y_WIDTH;
    localparam int         VY_W        = ball_link_pkg::VY_WIDTH;
    localparam int         G_W         = ball_link_pkg::GRAV_WIDTH;

    localparam int N_SINGLE     = 20;
    localparam int N_BUSY       = 4;
    localparam int N_ABORT      = 4;
    localparam int N_B2B        = 8;
    localparam int FRAME_BUDGET = 1500;  // ~1150 cycles per frame plus slack
    // an aborted frame and its follow-up count as two
    localparam int TIMEOUT_CYCLES = (N_SINGLE + N_BUSY + 2 * N_ABORT + N_B2B) * FRAME_BUDGET;

    logic                          clk;
    logic                          reset;
    logic                          send_trigger;
    logic [Y_W-1:0]                ball_y;
    logic [VY_W-1:0]               ball_vy;
    logic [G_W-1:0]                gravity_phase;
    logic                          collision;
    logic                          lose;
    logic                          abort;
    logic                          scl;
    logic                          sda;
    ball_link_pkg::sender_status_t status;
    logic                          link_error;
    logic                          rx_valid;
    logic [Y_W-1:0]                rx_ball_y;
    logic [VY_W-1:0]               rx_ball_vy;
    logic [G_W-1:0]                rx_gravity;
    logic                          rx_collision;
    logic                          rx_lose;

    logic [15:0] lfsr_state;
    logic [47:0] expected_q [$];  // packed frames in send order, byte 0 on top
    int          frames_expected = 0;
    int          rx_count = 0;
    int          cycle_count = 0;
    logic        saw_done = 1'b0;
    string       test_name = "reset";

    pong_link_top #(
        .CLK_DIV    (CLK_DIV),
        .TARGET_ADDR(TARGET_ADDR)
    ) pong_link_top_i (
        .clk          (clk),
        .reset        (reset),
        .send_trigger (send_trigger),
        .ball_y       (ball_y),
        .ball_vy      (ball_vy),
        .gravity_phase(gravity_phase),
        .collision    (collision),
        .lose         (lose),
        .abort        (abort),
        .scl          (scl),
        .sda          (sda),
        .status       (status),
        .link_error   (link_error),
        .rx_valid     (rx_valid),
        .rx_ball_y    (rx_ball_y),
        .rx_ball_vy   (rx_ball_vy),
        .rx_gravity   (rx_gravity),
        .rx_collision (rx_collision),
        .rx_lose      (rx_lose)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_random_fields();
        logic [31:0] r;
        take_bits(Y_W, r);
        ball_y = r[Y_W-1:0];
        take_bits(VY_W, r);
        ball_vy = r[VY_W-1:0];
        take_bits(G_W, r);
        gravity_phase = r[G_W-1:0];
        take_bits(1, r);
        collision = r[0];
        take_bits(1, r);
        lose = r[0];
    endtask

    // six data bytes as they go on the wire
    function automatic logic [47:0] pack_frame(input logic [Y_W-1:0] y,
                                               input logic [VY_W-1:0] vy,
                                               input logic [G_W-1:0] g,
                                               input logic c,
                                               input logic l);
        logic [7:0] b3;
        b3 = '0;
        b3[G_W-1:0] = g;
        return {y[9:8], 6'b0, y[7:0], vy, b3, 7'b0, c, 7'b0, l};
    endfunction

    task automatic check_y(input string what, input logic [Y_W-1:0] expected,
                           input logic [Y_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_byte(input string what, input logic [VY_W-1:0] expected,
                              input logic [VY_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_grav(input string what, input logic [G_W-1:0] expected,
                              input logic [G_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0b, actual %0b", test_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_status(input string what, input ball_link_pkg::sender_status_t expected,
                                input ball_link_pkg::sender_status_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            fail_run();
        end
    endtask

    always @(negedge clk) begin : rx_monitor
        logic [47:0] f;
        if (status == ball_link_pkg::ST_DONE) saw_done = 1'b1;
        if (!reset && rx_valid) begin
            rx_count++;
            if (expected_q.size() == 0) begin
                $display("%s: rx_valid pulsed with no frame outstanding", test_name);
                fail_run();
            end else begin
                f = expected_q.pop_front();
                check_y("rx_ball_y", {f[47:46], f[39:32]}, rx_ball_y);
                check_byte("rx_ball_vy", f[31:24], rx_ball_vy);
                check_grav("rx_gravity", f[16 +: G_W], rx_gravity);
                check_flag("rx_collision", f[8], rx_collision);
                check_flag("rx_lose", f[0], rx_lose);
            end
        end
    end

    task automatic trigger_frame();
        drive_random_fields();
        send_trigger = 1'b1;
        expected_q.push_back(pack_frame(ball_y, ball_vy, gravity_phase, collision, lose));
        frames_expected++;
        saw_done = 1'b0;
        @(negedge clk);
        send_trigger = 1'b0;
    endtask

    // optionally fires extra triggers while the sender is busy
    task automatic wait_frame_end(input int busy_max);
        int          fired;
        logic [31:0] r;
        fired = 0;
        while (status != ball_link_pkg::ST_IDLE) begin
            send_trigger = 1'b0;
            if (fired < busy_max) begin
                take_bits(5, r);
                if (r[4:0] == 5'd0) begin
                    drive_random_fields();
                    send_trigger = 1'b1;
                    fired++;
                end
            end
            @(negedge clk);
        end
        send_trigger = 1'b0;
    endtask

    task automatic check_frame_done();
        if (expected_q.size() != 0) begin
            $display("%s: frame was triggered but rx_valid never pulsed", test_name);
            fail_run();
        end
        check_flag("passed through done", 1'b1, saw_done);
        check_flag("link_error", 1'b0, link_error);
        check_status("status", ball_link_pkg::ST_IDLE, status);
    endtask

    task automatic run_frame(input int busy_max);
        trigger_frame();
        wait_frame_end(busy_max);
        check_frame_done();
    endtask

    initial begin : stimulus
        logic [31:0] r1;
        logic [31:0] r2;
        int          rx_before;
        reset         = 1'b1;
        send_trigger  = 1'b0;
        ball_y        = '0;
        ball_vy       = '0;
        gravity_phase = '0;
        collision     = 1'b0;
        lose          = 1'b0;
        abort         = 1'b0;
        lfsr_state    = 16'd50256;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_status("status", ball_link_pkg::ST_IDLE, status);
        check_flag("scl", 1'b1, scl);
        check_flag("sda", 1'b1, sda);
        check_flag("rx_valid", 1'b0, rx_valid);
        check_flag("link_error", 1'b0, link_error);
        check_y("rx_ball_y", '0, rx_ball_y);
        check_byte("rx_ball_vy", '0, rx_ball_vy);
        check_grav("rx_gravity", '0, rx_gravity);
        check_flag("rx_collision", 1'b0, rx_collision);
        check_flag("rx_lose", 1'b0, rx_lose);

        test_name = "single";
        for (int i = 0; i < N_SINGLE; i++) run_frame(0);

        test_name = "busy trigger";
        for (int i = 0; i < N_BUSY; i++) run_frame(6);

        test_name = "abort";
        for (int k = 0; k < N_ABORT; k++) begin
            rx_before = rx_count;
            drive_random_fields();
            send_trigger = 1'b1;
            saw_done = 1'b0;
            @(negedge clk);
            send_trigger = 1'b0;
            take_bits(9, r1);
            take_bits(8, r2);
            repeat (1 + int'(r1[8:0]) + int'(r2[7:0])) @(negedge clk);  // before last byte
            abort = 1'b1;
            @(negedge clk);
            abort = 1'b0;
            wait_frame_end(0);
            if (rx_count != rx_before) begin
                $display("abort: rx_valid pulsed for an aborted frame");
                fail_run();
            end
            check_flag("scl released", 1'b1, scl);
            check_flag("sda released", 1'b1, sda);
            check_frame_done();
            run_frame(0);
        end

        test_name = "back-to-back";
        for (int i = 0; i < N_B2B; i++) run_frame(0);

        test_name = "rx_valid count";
        if (rx_count != frames_expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", test_name, frames_expected, rx_count);
            fail_run();
        end

        if (pong_link_top_i.i2c_byte_master_i.pong_link_props_i.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("bus assertions failed during the run");
            fail_run();
        end
    end

endmodule

// ==== tests/pong_link_props.sv ====
`timescale 1ns/100ps

module pong_link_props (
    input logic              clk,
    input logic              reset,
    input i2c_pkg::i2c_cmd_t cmd,
    input i2c_pkg::i2c_cmd_t op,
    input logic              ready,
    input logic              tx_done,
    input logic              scl,
    input logic              sda
);

    int fail_count = 0;  // read by the testbench at the end

    // busy master sees only the accepted command, held until ready falls
    no_cmd_while_busy: assert property (@(posedge clk) disable iff (reset)
        !ready && cmd != i2c_pkg::CMD_NONE |-> $past(ready) && cmd == $past(cmd))
        else begin
            fail_count++;
            $error("new command presented while ready was low");
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        tx_done |=> !tx_done)
        else begin
            fail_count++;
            $error("tx_done held for more than one cycle");
        end

    // data moves only with scl low, start and stop excepted
    sda_stable_scl_high: assert property (@(posedge clk) disable iff (reset)
        scl && $past(scl) && sda != $past(sda) |->
            op == i2c_pkg::CMD_START || op == i2c_pkg::CMD_STOP)
        else begin
            fail_count++;
            $error("sda changed while scl was high outside start or stop");
        end

endmodule

bind i2c_byte_master pong_link_props pong_link_props_i (
    .clk    (clk),
    .reset  (reset),
    .cmd    (cmd),
    .op     (op),
    .ready  (ready),
    .tx_done(tx_done),
    .scl    (scl_in),
    .sda    (sda_in)
);

// ==== hdl/pong_link_top.sv ====
`timescale 1ns/100ps

module pong_link_top #(
    parameter int         CLK_DIV     = 4,
    parameter logic [6:0] TARGET_ADDR = 7'h55
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 send_trigger,
    input  logic [ball_link_pkg::Y_WIDTH-1:0]    ball_y,
    input  logic [ball_link_pkg::VY_WIDTH-1:0]   ball_vy,
    input  logic [ball_link_pkg::GRAV_WIDTH-1:0] gravity_phase,
    input  logic                                 collision,
    input  logic                                 lose,
    input  logic                                 abort,
    output logic                                 scl,
    output logic                                 sda,
    output ball_link_pkg::sender_status_t        status,
    output logic                                 link_error,
    output logic                                 rx_valid,
    output logic [ball_link_pkg::Y_WIDTH-1:0]    rx_ball_y,
    output logic [ball_link_pkg::VY_WIDTH-1:0]   rx_ball_vy,
    output logic [ball_link_pkg::GRAV_WIDTH-1:0] rx_gravity,
    output logic                                 rx_collision,
    output logic                                 rx_lose
);

    i2c_pkg::i2c_cmd_t cmd;
    logic [7:0]        tx_data;
    logic              ready;
    logic              tx_done;
    logic              nack;
    logic              master_scl_low;
    logic              master_sda_low;
    logic              target_sda_low;

    // open drain, pulled up when nobody pulls low
    assign scl = !master_scl_low;
    assign sda = !(master_sda_low || target_sda_low);

    ball_frame_sender #(
        .TARGET_ADDR(TARGET_ADDR)
    ) ball_frame_sender_i (
        .clk          (clk),
        .reset        (reset),
        .send_trigger (send_trigger),
        .ball_y       (ball_y),
        .ball_vy      (ball_vy),
        .gravity_phase(gravity_phase),
        .collision    (collision),
        .lose         (lose),
        .abort        (abort),
        .ready        (ready),
        .tx_done      (tx_done),
        .nack         (nack),
        .cmd          (cmd),
        .tx_data      (tx_data),
        .status       (status),
        .link_error   (link_error)
    );

    i2c_byte_master #(
        .CLK_DIV(CLK_DIV)
    ) i2c_byte_master_i (
        .clk    (clk),
        .reset  (reset),
        .cmd    (cmd),
        .tx_data(tx_data),
        .scl_in (scl),
        .sda_in (sda),
        .ready  (ready),
        .tx_done(tx_done),
        .nack   (nack),
        .scl_low(master_scl_low),
        .sda_low(master_sda_low)
    );

    i2c_frame_receiver #(
        .TARGET_ADDR(TARGET_ADDR)
    ) i2c_frame_receiver_i (
        .clk         (clk),
        .reset       (reset),
        .scl         (scl),
        .sda         (sda),
        .sda_low     (target_sda_low),
        .rx_valid    (rx_valid),
        .rx_ball_y   (rx_ball_y),
        .rx_ball_vy  (rx_ball_vy),
        .rx_gravity  (rx_gravity),
        .rx_collision(rx_collision),
        .rx_lose     (rx_lose)
    );

endmodule

// ==== hdl/i2c_frame_receiver.sv ====
`timescale 1ns/100ps

module i2c_frame_receiver #(
    parameter logic [6:0] TARGET_ADDR = 7'h55
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 scl,
    input  logic                                 sda,
    output logic                                 sda_low,
    output logic                                 rx_valid,
    output logic [ball_link_pkg::Y_WIDTH-1:0]    rx_ball_y,
    output logic [ball_link_pkg::VY_WIDTH-1:0]   rx_ball_vy,
    output logic [ball_link_pkg::GRAV_WIDTH-1:0] rx_gravity,
    output logic                                 rx_collision,
    output logic                                 rx_lose
);

    localparam int CNT_W = $clog2(ball_link_pkg::FRAME_BYTES + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(ball_link_pkg::FRAME_BYTES);

    logic [1:0]       scl_sync;
    logic [1:0]       sda_sync;
    logic             scl_prev;
    logic             sda_prev;
    logic             scl_rise;
    logic             scl_fall;
    logic             start_det;
    logic             stop_det;
    logic [3:0]       bit_cnt;  // 8 after a byte, 9 during ack
    logic [7:0]       shift;
    logic             addr_phase;
    logic             addressed;
    logic             addr_match;
    logic             byte_end;
    logic             store;
    logic             frame_ok;
    logic [CNT_W-1:0] byte_cnt;
    logic [7:0]       rx_bytes [ball_link_pkg::FRAME_BYTES];

    assign scl_rise   = scl_sync[1] && !scl_prev;
    assign scl_fall   = !scl_sync[1] && scl_prev;
    assign start_det  = scl_sync[1] && scl_prev && sda_prev && !sda_sync[1];
    assign stop_det   = scl_sync[1] && scl_prev && !sda_prev && sda_sync[1];
    assign addr_match = (shift[7:1] == TARGET_ADDR) && !shift[0];
    assign byte_end   = scl_fall && bit_cnt == 4'd8 && !start_det && !stop_det;
    assign store      = byte_end && !addr_phase && addressed && byte_cnt != FULL;
    assign frame_ok   = stop_det && addressed && byte_cnt == FULL;

    always_ff @(posedge clk) begin
        if (scl_rise && bit_cnt < 4'd8) shift <= {shift[6:0], sda_sync[1]};
        if (store) rx_bytes[byte_cnt] <= shift;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scl_sync     <= 2'b11;
            sda_sync     <= 2'b11;
            scl_prev     <= 1'b1;
            sda_prev     <= 1'b1;
            bit_cnt      <= '0;
            addr_phase   <= 1'b0;
            addressed    <= 1'b0;
            byte_cnt     <= '0;
            sda_low      <= 1'b0;
            rx_valid     <= 1'b0;
            rx_ball_y    <= '0;
            rx_ball_vy   <= '0;
            rx_gravity   <= '0;
            rx_collision <= 1'b0;
            rx_lose      <= 1'b0;
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda};
            scl_prev <= scl_sync[1];
            sda_prev <= sda_sync[1];
            rx_valid <= frame_ok;

            if (frame_ok) begin
                rx_ball_y    <= {rx_bytes[0][7:6], rx_bytes[1]};
                rx_ball_vy   <= rx_bytes[2];
                rx_gravity   <= rx_bytes[3][ball_link_pkg::GRAV_WIDTH-1:0];
                rx_collision <= rx_bytes[4][0];
                rx_lose      <= rx_bytes[5][0];
            end

            if (start_det) begin
                bit_cnt    <= '0;
                addr_phase <= 1'b1;
                addressed  <= 1'b0;
                byte_cnt   <= '0;
                sda_low    <= 1'b0;
            end else if (stop_det) begin
                bit_cnt    <= '0;
                addr_phase <= 1'b0;
                addressed  <= 1'b0;
                sda_low    <= 1'b0;
            end else if (scl_rise && bit_cnt < 4'd8) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else if (byte_end) begin
                bit_cnt <= 4'd9;
                if (addr_phase) begin
                    addr_phase <= 1'b0;
                    addressed  <= addr_match;
                    sda_low    <= addr_match;  // ack own address only
                end else if (store) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    sda_low  <= 1'b1;
                end else begin
                    addressed <= 1'b0;  // frame too long
                end
            end else if (scl_fall && bit_cnt == 4'd9) begin
                bit_cnt <= '0;
                sda_low <= 1'b0;  // release after ack clock
            end
        end
    end

endmodule

// ==== hdl/i2c_byte_master.sv ====
`timescale 1ns/100ps

module i2c_byte_master #(
    parameter int CLK_DIV = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  i2c_pkg::i2c_cmd_t cmd,
    input  logic [7:0]        tx_data,
    input  logic              scl_in,
    input  logic              sda_in,
    output logic              ready,
    output logic              tx_done,
    output logic              nack,
    output logic              scl_low,
    output logic              sda_low
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int PH_W  = $clog2(i2c_pkg::PHASES_PER_BIT);
    localparam logic [PH_W-1:0] LAST_PHASE = PH_W'(i2c_pkg::PHASES_PER_BIT - 1);
    localparam logic [PH_W-1:0] MID_PHASE  = PH_W'(i2c_pkg::PHASES_PER_BIT / 2);

    i2c_pkg::i2c_cmd_t op;  // operation in progress, none when ready
    logic [DIV_W-1:0]  div_cnt;
    logic [PH_W-1:0]   phase;
    logic [3:0]        bit_cnt;  // 8 is the ack bit
    logic [7:0]        shift;
    logic              tick;
    logic              accept;
    logic              last_quarter;
    logic              scl_next;
    logic              sda_next;

    assign ready        = (op == i2c_pkg::CMD_NONE);
    assign accept       = ready && cmd != i2c_pkg::CMD_NONE;
    assign tick         = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_quarter = tick && phase == LAST_PHASE &&
                          (op != i2c_pkg::CMD_WRITE || bit_cnt == 4'd8);

    // line levels for the current quarter, registered one clk later
    always_comb begin
        scl_next = scl_low;
        sda_next = sda_low;
        case (op)
            i2c_pkg::CMD_START: begin
                sda_next = (phase != '0);         // sda falls with scl high
                scl_next = (phase == LAST_PHASE);
            end
            i2c_pkg::CMD_WRITE: begin
                scl_next = (phase == '0) || (phase == LAST_PHASE);
                sda_next = (bit_cnt != 4'd8) && !shift[7];  // released for ack
            end
            i2c_pkg::CMD_STOP: begin
                scl_next = (phase == '0);
                sda_next = (phase < MID_PHASE);   // sda rises with scl high
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shift <= tx_data;
        end else if (op == i2c_pkg::CMD_WRITE && tick && phase == LAST_PHASE) begin
            shift <= {shift[6:0], 1'b0};  // msb first
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op      <= i2c_pkg::CMD_NONE;
            tx_done <= 1'b0;
            nack    <= 1'b0;
            div_cnt <= '0;
            phase   <= '0;
            bit_cnt <= '0;
            scl_low <= 1'b0;
            sda_low <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            scl_low <= scl_next;
            sda_low <= sda_next;
            if (accept) begin
                op      <= cmd;
                div_cnt <= '0;
                phase   <= '0;
                bit_cnt <= '0;
                if (cmd == i2c_pkg::CMD_WRITE) nack <= 1'b0;
            end else if (op != i2c_pkg::CMD_NONE) begin
                if (tick) begin
                    div_cnt <= '0;
                    phase   <= phase + 1'b1;
                    if (op == i2c_pkg::CMD_WRITE && phase == LAST_PHASE) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    // ack sampled late in scl high
                    if (op == i2c_pkg::CMD_WRITE && bit_cnt == 4'd8 &&
                        phase == MID_PHASE && scl_in) begin
                        nack <= sda_in;
                    end
                    if (last_quarter) begin
                        op      <= i2c_pkg::CMD_NONE;
                        tx_done <= 1'b1;
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/ball_frame_sender.sv ====
`timescale 1ns/100ps

module ball_frame_sender #(
    parameter logic [6:0] TARGET_ADDR = 7'h55
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 send_trigger,
    input  logic [ball_link_pkg::Y_WIDTH-1:0]    ball_y,
    input  logic [ball_link_pkg::VY_WIDTH-1:0]   ball_vy,
    input  logic [ball_link_pkg::GRAV_WIDTH-1:0] gravity_phase,
    input  logic                                 collision,
    input  logic                                 lose,
    input  logic                                 abort,
    input  logic                                 ready,
    input  logic                                 tx_done,
    input  logic                                 nack,
    output i2c_pkg::i2c_cmd_t                    cmd,
    output logic [7:0]                           tx_data,
    output ball_link_pkg::sender_status_t        status,
    output logic                                 link_error
);

    localparam int IDX_W = $clog2(ball_link_pkg::FRAME_BYTES + 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(ball_link_pkg::FRAME_BYTES);

    ball_link_pkg::sender_status_t state, state_next;
    i2c_pkg::i2c_cmd_t last_cmd, last_cmd_next;  // last command handed to the master
    logic [IDX_W-1:0] idx, idx_next;
    logic             abort_pend, abort_pend_next;
    logic             link_error_next;
    logic             load;

    // address byte in slot 0, data bytes after it
    logic [7:0] msg_q [ball_link_pkg::FRAME_BYTES + 1];

    assign status  = state;
    assign tx_data = msg_q[idx];

    always_ff @(posedge clk) begin
        if (load) begin
            msg_q[0] <= {TARGET_ADDR, 1'b0};  // write
            msg_q[1] <= {ball_y[9:8], 6'b0};
            msg_q[2] <= ball_y[7:0];
            msg_q[3] <= ball_vy;
            msg_q[4] <= 8'(gravity_phase);
            msg_q[5] <= {7'b0, collision};
            msg_q[6] <= {7'b0, lose};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= ball_link_pkg::ST_IDLE;
            last_cmd   <= i2c_pkg::CMD_NONE;
            idx        <= '0;
            abort_pend <= 1'b0;
            link_error <= 1'b0;
        end else begin
            state      <= state_next;
            last_cmd   <= last_cmd_next;
            idx        <= idx_next;
            abort_pend <= abort_pend_next;
            link_error <= link_error_next;
        end
    end

    always_comb begin
        state_next      = state;
        last_cmd_next   = last_cmd;
        idx_next        = idx;
        abort_pend_next = abort_pend;
        link_error_next = link_error;
        load            = 1'b0;
        cmd             = i2c_pkg::CMD_NONE;

        if (abort && last_cmd != i2c_pkg::CMD_STOP &&
            state inside {ball_link_pkg::ST_START, ball_link_pkg::ST_WAIT,
                          ball_link_pkg::ST_DATA}) begin
            abort_pend_next = 1'b1;
        end

        case (state)
            ball_link_pkg::ST_IDLE: begin
                idx_next        = '0;
                abort_pend_next = 1'b0;
                last_cmd_next   = i2c_pkg::CMD_NONE;
                if (send_trigger) begin
                    load       = 1'b1;
                    state_next = ball_link_pkg::ST_START;
                end
            end
            ball_link_pkg::ST_START: begin
                cmd = i2c_pkg::CMD_START;
                if (!ready) state_next = ball_link_pkg::ST_WAIT;
            end
            ball_link_pkg::ST_WAIT: begin
                if (ready) begin
                    if (last_cmd == i2c_pkg::CMD_STOP) begin
                        state_next = ball_link_pkg::ST_DONE;
                    end else if (tx_done && nack && last_cmd == i2c_pkg::CMD_WRITE) begin
                        link_error_next = 1'b1;
                        state_next      = ball_link_pkg::ST_STOP;
                    end else if (abort_pend || abort) begin
                        state_next = ball_link_pkg::ST_STOP;
                    end else if (last_cmd == i2c_pkg::CMD_START) begin
                        state_next = ball_link_pkg::ST_DATA;  // address byte
                    end else if (idx == LAST_IDX) begin
                        state_next = ball_link_pkg::ST_STOP;
                    end else begin
                        idx_next   = idx + 1'b1;
                        state_next = ball_link_pkg::ST_DATA;
                    end
                end
            end
            ball_link_pkg::ST_DATA: begin
                cmd = i2c_pkg::CMD_WRITE;
                if (!ready) state_next = ball_link_pkg::ST_WAIT;
            end
            ball_link_pkg::ST_STOP: begin
                cmd = i2c_pkg::CMD_STOP;
                if (!ready) state_next = ball_link_pkg::ST_WAIT;
            end
            default: begin  // done
                state_next = ball_link_pkg::ST_IDLE;
            end
        endcase

        if (cmd != i2c_pkg::CMD_NONE) last_cmd_next = cmd;
    end

endmodule

// ==== hdl/i2c_pkg.sv ====
package i2c_pkg;

    // byte master commands
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_START = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_STOP  = 2'd3
    } i2c_cmd_t;

    // quarter phases per scl bit
    localparam int PHASES_PER_BIT = 4;

endpackage

// ==== hdl/ball_link_pkg.sv ====
package ball_link_pkg;

    // field widths of the ball state
    localparam int Y_WIDTH    = 10;
    localparam int VY_WIDTH   = 8;
    localparam int GRAV_WIDTH = 2;

    // data bytes per frame, address byte not counted
    // 0: y[9:8] in bits 7:6
    // 1: y[7:0]
    // 2: vy
    // 3: gravity phase in low bits
    // 4: collision in bit 0
    // 5: lose in bit 0
    localparam int FRAME_BYTES = 6;

    // one-hot, drives the status leds
    typedef enum logic [7:0] {
        ST_IDLE  = 8'b0000_0001,
        ST_START = 8'b0000_0010,
        ST_WAIT  = 8'b0000_0100,
        ST_DATA  = 8'b0000_1000,
        ST_STOP  = 8'b0001_0000,
        ST_DONE  = 8'b0010_0000
    } sender_status_t;

endpackage
